//--- common/periph_pkg.sv
package periph_pkg;

    ////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////

    localparam int bus_addr_w = 32;
    localparam int bus_data_w = 32;
    localparam int bus_be_w   = bus_data_w / 8;
    localparam int offset_w   = 24;                  // low address bits inside one region.
    localparam int region_w   = bus_addr_w - offset_w;

    typedef logic [bus_addr_w-1:0] bus_addr_t;
    typedef logic [bus_data_w-1:0] bus_data_t;
    typedef logic [bus_be_w-1:0]   bus_be_t;
    typedef logic [offset_w-1:0]   reg_offset_t;

    // top address byte of each peripheral window.
    typedef enum logic [region_w-1:0] {
        region_rtc  = 8'h02,
        region_plic = 8'h0C,
        region_none = 8'hFF
    } region_t;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    localparam reg_offset_t plic_off_claim   = 24'h000000;
    localparam reg_offset_t plic_off_pending = 24'h001000;
    localparam reg_offset_t plic_off_enable  = 24'h002000;

    localparam reg_offset_t rtc_off_mtime_lo = 24'h000000;
    localparam reg_offset_t rtc_off_mtime_hi = 24'h000004;
    localparam reg_offset_t rtc_off_cmp_lo   = 24'h000008;
    localparam reg_offset_t rtc_off_cmp_hi   = 24'h00000C;

endpackage

//--- common/irq_pkg.sv
package irq_pkg;

    ////////////////////////////////////////
    // interrupt sources
    ////////////////////////////////////////

    // source 0 is reserved for "no interrupt", so one data word holds 31 sources.
    localparam int irq_max  = 31;
    localparam int irq_id_w = $clog2(irq_max + 1);

    typedef logic [irq_id_w-1:0] irq_id_t;   // source number, 0 means none.
    typedef logic [irq_max:0]    irq_vec_t;  // one bit per source, bit 0 stays clear.

    ////////////////////////////////////////
    // machine timer
    ////////////////////////////////////////

    localparam int mtime_w = 64;

    typedef logic [mtime_w-1:0] mtime_t;

endpackage

//--- plic/plic.sv
module plic #(
    parameter int irq_count = 8
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    en_i,
    input  periph_pkg::bus_be_t     we_i,
    input  periph_pkg::reg_offset_t offset_i,
    input  periph_pkg::bus_data_t   data_i,
    output periph_pkg::bus_data_t   data_o,

    input  logic [irq_count:1]      irq_i,
    input  logic                    iack_i,
    output logic [irq_count:1]      iack_o,
    output logic                    irq_o
);
    import periph_pkg::*;
    import irq_pkg::*;

    logic [irq_count:1] ip;         // sources sampled one cycle ago.
    logic [irq_count:1] ie;         // software enable mask.
    logic [irq_count:1] active;     // pending and enabled.
    irq_id_t            id_next;    // winner of the current scan.
    irq_id_t            claim_id;   // id taken by the last claim.
    irq_vec_t           ip_word;
    irq_vec_t           ie_word;
    logic               wr;
    logic               rd;

    if (irq_count < 1 || irq_count > irq_max) begin : g_count_check
        $error("plic: irq_count must be between 1 and %0d", irq_max);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip <= '0;
        end else begin
            ip <= irq_i;                                  // level sources, no edge latch.
        end
    end

    assign active = ip & ie;

    // fixed priority, the lowest source number wins.
    always_comb begin
        id_next = '0;
        for (int i = irq_count; i >= 1; i--) begin
            if (active[i]) begin
                id_next = irq_id_t'(i);
            end
        end
    end

    assign irq_o = (|active) & ~iack_i;

    always_comb begin
        for (int i = 1; i <= irq_count; i++) begin
            iack_o[i] = iack_i && (id_next == irq_id_t'(i));   // zero when nothing is pending.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            claim_id <= '0;
        end else if (iack_i) begin
            claim_id <= id_next;
        end
    end

    ////////////////////////////////////////
    // memory mapped registers
    ////////////////////////////////////////

    assign wr = en_i && (we_i != '0);                     // any byte lane writes the word.
    assign rd = en_i && (we_i == '0);

    always_comb begin
        ip_word = '0;
        ie_word = '0;
        ip_word[irq_count:1] = ip;
        ie_word[irq_count:1] = ie;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ie <= '0;
        end else if (wr && offset_i == plic_off_enable) begin
            ie <= data_i[irq_count:1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_o <= '0;
        end else if (rd) begin
            case (offset_i)
                plic_off_claim:   data_o <= bus_data_t'(claim_id);
                plic_off_pending: data_o <= bus_data_t'(ip_word);
                plic_off_enable:  data_o <= bus_data_t'(ie_word);
                default:          data_o <= '0;
            endcase
        end
    end

endmodule

//--- logic/rtc.sv
module rtc (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    en_i,
    input  periph_pkg::bus_be_t     we_i,
    input  periph_pkg::reg_offset_t offset_i,
    input  periph_pkg::bus_data_t   data_i,
    output periph_pkg::bus_data_t   data_o,

    output logic                    mti_o
);
    import periph_pkg::*;
    import irq_pkg::*;

    localparam int half_w = $bits(bus_data_t);

    mtime_t mtime;
    mtime_t mtimecmp;
    logic   wr;
    logic   rd;

    assign wr = en_i && (we_i != '0);
    assign rd = en_i && (we_i == '0);

    ////////////////////////////////////////
    // counter and compare
    ////////////////////////////////////////

    // a write to either half takes the place of the increment for that cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime <= '0;
        end else if (wr && offset_i == rtc_off_mtime_lo) begin
            mtime <= {mtime[mtime_w-1:half_w], data_i};
        end else if (wr && offset_i == rtc_off_mtime_hi) begin
            mtime <= {data_i, mtime[half_w-1:0]};
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp <= '1;                               // far future, no interrupt.
        end else if (wr && offset_i == rtc_off_cmp_lo) begin
            mtimecmp <= {mtimecmp[mtime_w-1:half_w], data_i};
        end else if (wr && offset_i == rtc_off_cmp_hi) begin
            mtimecmp <= {data_i, mtimecmp[half_w-1:0]};
        end
    end

    assign mti_o = (mtime >= mtimecmp);                   // stays up until software moves cmp.

    ////////////////////////////////////////
    // read back
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            data_o <= '0;
        end else if (rd) begin
            case (offset_i)
                rtc_off_mtime_lo: data_o <= mtime[half_w-1:0];
                rtc_off_mtime_hi: data_o <= mtime[mtime_w-1:half_w];
                rtc_off_cmp_lo:   data_o <= mtimecmp[half_w-1:0];
                rtc_off_cmp_hi:   data_o <= mtimecmp[mtime_w-1:half_w];
                default:          data_o <= '0;
            endcase
        end
    end

endmodule

//--- logic/periph_bus.sv
module periph_bus (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    en_i,
    input  periph_pkg::bus_be_t     we_i,
    input  periph_pkg::bus_addr_t   addr_i,

    output logic                    plic_en_o,
    output logic                    rtc_en_o,
    output periph_pkg::reg_offset_t offset_o,

    input  periph_pkg::bus_data_t   plic_data_i,
    input  periph_pkg::bus_data_t   rtc_data_i,
    output periph_pkg::bus_data_t   data_o
);
    import periph_pkg::*;

    region_t region;      // window hit by the current access.
    region_t rd_region;   // window of the last read, steers the return mux.

    always_comb begin
        case (addr_i[bus_addr_w-1:offset_w])
            region_rtc:  region = region_rtc;
            region_plic: region = region_plic;
            default:     region = region_none;
        endcase
    end

    assign plic_en_o = en_i && (region == region_plic);
    assign rtc_en_o  = en_i && (region == region_rtc);
    assign offset_o  = addr_i[offset_w-1:0];

    // writes leave the selection alone so data_o holds until the next read.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_region <= region_none;
        end else if (en_i && we_i == '0) begin
            rd_region <= region;
        end
    end

    always_comb begin
        case (rd_region)
            region_plic: data_o = plic_data_i;
            region_rtc:  data_o = rtc_data_i;
            default:     data_o = '0;                     // unmapped reads return zero.
        endcase
    end

endmodule

//--- logic/periph_top.sv
module periph_top #(
    parameter int irq_count = 8
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  en_i,
    input  periph_pkg::bus_be_t   we_i,
    input  periph_pkg::bus_addr_t addr_i,
    input  periph_pkg::bus_data_t data_i,
    output periph_pkg::bus_data_t data_o,

    input  logic [irq_count:1]    irq_i,
    input  logic                  iack_i,
    output logic [irq_count:1]    iack_o,
    output logic                  irq_o,
    output logic                  mti_o
);
    import periph_pkg::*;

    logic        plic_en;
    logic        rtc_en;
    reg_offset_t offset;
    bus_data_t   plic_data;
    bus_data_t   rtc_data;

    ////////////////////////////////////////
    // decode and return path
    ////////////////////////////////////////

    periph_bus periph_bus_inst (
        .clk         (clk),
        .reset       (reset),
        .en_i        (en_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .plic_en_o   (plic_en),
        .rtc_en_o    (rtc_en),
        .offset_o    (offset),
        .plic_data_i (plic_data),
        .rtc_data_i  (rtc_data),
        .data_o      (data_o)
    );

    ////////////////////////////////////////
    // peripherals
    ////////////////////////////////////////

    // write enables and data fan out to both, each block qualifies them with its enable.
    plic #(
        .irq_count (irq_count)
    ) plic_inst (
        .clk      (clk),
        .reset    (reset),
        .en_i     (plic_en),
        .we_i     (we_i),
        .offset_i (offset),
        .data_i   (data_i),
        .data_o   (plic_data),
        .irq_i    (irq_i),
        .iack_i   (iack_i),
        .iack_o   (iack_o),
        .irq_o    (irq_o)
    );

    rtc rtc_inst (
        .clk      (clk),
        .reset    (reset),
        .en_i     (rtc_en),
        .we_i     (we_i),
        .offset_i (offset),
        .data_i   (data_i),
        .data_o   (rtc_data),
        .mti_o    (mti_o)
    );

endmodule

//--- testbench/periph_props.sv
module periph_props #(
    parameter int irq_count = 8
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  en_i,
    input periph_pkg::bus_be_t   we_i,
    input periph_pkg::bus_addr_t addr_i,
    input periph_pkg::bus_data_t data_i,
    input periph_pkg::bus_data_t data_o,
    input logic [irq_count:1]    irq_i,
    input logic                  iack_i,
    input logic [irq_count:1]    iack_o,
    input logic                  irq_o,
    input logic                  mti_o
);
    import periph_pkg::*;
    import irq_pkg::*;

    logic [irq_count:1] ip_sh;          // irq_i delayed by one cycle as pending sees it.
    logic [irq_count:1] ie_sh;          // enable mask as last written over the bus.
    logic [irq_count:1] active_sh;
    logic [irq_count:1] first_sh;       // one-hot of the lowest enabled pending source.
    irq_id_t            claim_sh;
    mtime_t             mtime_sh;
    mtime_t             cmp_sh;
    bus_data_t          rd_exp;         // word the last read has to return.
    logic               rd_pend;
    logic               reset_d = 1'b0;
    int                 fail_count = 0;

    assign active_sh = ip_sh & ie_sh;
    assign first_sh  = active_sh & -active_sh;    // two's complement keeps the lowest set bit.

    function automatic logic wr_to(input bus_addr_t a);
        return en_i && (we_i != '0) && (addr_i == a);
    endfunction

    function automatic irq_id_t id_of(input logic [irq_count:1] onehot);
        irq_id_t id;
        id = '0;
        for (int i = 1; i <= irq_count; i++) begin
            if (onehot[i]) begin
                id = irq_id_t'(i);
            end
        end
        return id;
    endfunction

    function automatic bus_data_t read_value(input bus_addr_t addr);
        bus_data_t v;
        v = '0;
        if (addr[bus_addr_w-1:offset_w] == region_plic) begin
            case (reg_offset_t'(addr))
                plic_off_claim:   v = bus_data_t'(claim_sh);
                plic_off_pending: v[irq_count:1] = ip_sh;
                plic_off_enable:  v[irq_count:1] = ie_sh;
                default:          v = '0;
            endcase
        end else if (addr[bus_addr_w-1:offset_w] == region_rtc) begin
            case (reg_offset_t'(addr))
                rtc_off_mtime_lo: v = mtime_sh[31:0];
                rtc_off_mtime_hi: v = mtime_sh[63:32];
                rtc_off_cmp_lo:   v = cmp_sh[31:0];
                rtc_off_cmp_hi:   v = cmp_sh[63:32];
                default:          v = '0;
            endcase
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // shadow state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        reset_d <= reset;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip_sh    <= '0;
            ie_sh    <= '0;
            claim_sh <= '0;
            mtime_sh <= '0;
            cmp_sh   <= '1;
            rd_pend  <= 1'b0;
            rd_exp   <= '0;
        end else begin
            ip_sh   <= irq_i;
            rd_pend <= en_i && (we_i == '0);
            rd_exp  <= read_value(addr_i);
            if (wr_to({region_plic, plic_off_enable})) begin
                ie_sh <= data_i[irq_count:1];
            end
            if (iack_i) begin
                claim_sh <= id_of(first_sh);
            end
            if (wr_to({region_rtc, rtc_off_mtime_lo})) begin
                mtime_sh <= {mtime_sh[63:32], data_i};
            end else if (wr_to({region_rtc, rtc_off_mtime_hi})) begin
                mtime_sh <= {data_i, mtime_sh[31:0]};
            end else begin
                mtime_sh <= mtime_sh + 64'd1;
            end
            if (wr_to({region_rtc, rtc_off_cmp_lo})) begin
                cmp_sh <= {cmp_sh[63:32], data_i};
            end else if (wr_to({region_rtc, rtc_off_cmp_hi})) begin
                cmp_sh <= {data_i, cmp_sh[31:0]};
            end
        end
    end

    ////////////////////////////////////////
    // rules
    ////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk) reset_d |-> !irq_o && iack_o == '0 && !mti_o)
        else begin
            $error("outputs not quiet during or right after reset");
            fail_count++;
        end

    a_irq: assert property (@(posedge clk) disable iff (reset)
        irq_o == ((|active_sh) && !iack_i))
        else begin
            $error("[ERROR] irq request: expected %0b, actual %0b",
                   ($sampled(active_sh) != '0) && !$sampled(iack_i), $sampled(irq_o));
            fail_count++;
        end

    a_claim: assert property (@(posedge clk) disable iff (reset) iack_i |-> iack_o == first_sh)
        else begin
            $error("[ERROR] claim ack: expected 0x%0h, actual 0x%0h",
                   $sampled(first_sh), $sampled(iack_o));
            fail_count++;
        end

    a_no_ack: assert property (@(posedge clk) disable iff (reset) !iack_i |-> iack_o == '0)
        else begin
            $error("[ERROR] ack without claim: expected 0x0, actual 0x%0h", $sampled(iack_o));
            fail_count++;
        end

    a_read: assert property (@(posedge clk) disable iff (reset) rd_pend |-> data_o == rd_exp)
        else begin
            $error("[ERROR] bus read: expected 0x%08h, actual 0x%08h",
                   $sampled(rd_exp), $sampled(data_o));
            fail_count++;
        end

    a_timer: assert property (@(posedge clk) disable iff (reset) mti_o == (mtime_sh >= cmp_sh))
        else begin
            $error("[ERROR] timer interrupt: expected %0b, actual %0b",
                   $sampled(mtime_sh) >= $sampled(cmp_sh), $sampled(mti_o));
            fail_count++;
        end

endmodule

bind periph_top periph_props #(
    .irq_count (irq_count)
) periph_props_inst (
    .clk    (clk),
    .reset  (reset),
    .en_i   (en_i),
    .we_i   (we_i),
    .addr_i (addr_i),
    .data_i (data_i),
    .data_o (data_o),
    .irq_i  (irq_i),
    .iack_i (iack_i),
    .iack_o (iack_o),
    .irq_o  (irq_o),
    .mti_o  (mti_o)
);

//--- testbench/periph_tb.sv
module periph_tb;
    import periph_pkg::*;

    localparam int irq_count   = 8;
    localparam int phase_count = 4;
    localparam int cycle_time  = 100;

    localparam bus_addr_t claim_addr    = {region_plic, plic_off_claim};
    localparam bus_addr_t pending_addr  = {region_plic, plic_off_pending};
    localparam bus_addr_t enable_addr   = {region_plic, plic_off_enable};
    localparam bus_addr_t mtime_lo_addr = {region_rtc, rtc_off_mtime_lo};
    localparam bus_addr_t mtime_hi_addr = {region_rtc, rtc_off_mtime_hi};
    localparam bus_addr_t cmp_lo_addr   = {region_rtc, rtc_off_cmp_lo};
    localparam bus_addr_t cmp_hi_addr   = {region_rtc, rtc_off_cmp_hi};

    logic               clk = 1'b0;
    logic               reset;
    logic               en_i;
    bus_be_t            we_i;
    bus_addr_t          addr_i;
    bus_data_t          data_i;
    bus_data_t          data_o;
    logic [irq_count:1] irq_i;
    logic               iack_i;
    logic [irq_count:1] iack_o;
    logic               irq_o;
    logic               mti_o;
    int                 seed;
    bus_data_t          rd_data;
    bus_data_t          first_lo;

    periph_top #(
        .irq_count (irq_count)
    ) periph_top_inst (
        .clk (clk), .reset (reset), .en_i (en_i), .we_i (we_i), .addr_i (addr_i),
        .data_i (data_i), .data_o (data_o), .irq_i (irq_i), .iack_i (iack_i),
        .iack_o (iack_o), .irq_o (irq_o), .mti_o (mti_o)
    );

    always #(cycle_time / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string test, input bus_data_t expected,
                               input bus_data_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
            stop_with_failure("a checked value was wrong");
        end
    endtask

    // every bus task starts and ends 10 units after a rising edge.
    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        en_i   = 1'b1;
        we_i   = 4'hF;
        addr_i = addr;
        data_i = data;
        @(posedge clk);
        #10;
        en_i = 1'b0;
        we_i = '0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        en_i   = 1'b1;
        we_i   = '0;
        addr_i = addr;
        @(posedge clk);
        #10;
        en_i = 1'b0;
        data = data_o;                                // registered word is back one cycle later.
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic claim_pulse();
        iack_i = 1'b1;
        idle(1);
        iack_i = 1'b0;
    endtask

    always @(negedge clk) begin
        if (periph_top_inst.periph_props_inst.fail_count != 0) begin
            stop_with_failure("an assertion on the DUT failed");
        end
    end

    initial begin
        #(phase_count * 200 * cycle_time);
        stop_with_failure("watchdog expired before the test sequence finished");
    end

    initial begin
        seed   = 32922;
        reset  = 1'b1;
        en_i   = 1'b0;
        we_i   = '0;
        addr_i = '0;
        data_i = '0;
        irq_i  = '0;
        iack_i = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        ////////////////////////////////////////
        bus_read(enable_addr, rd_data);
        check_value("enable after reset", 32'h0, rd_data);

        // each round sets random sources and then claims and reads them back.
        for (int n = 0; n < 24; n++) begin
            if (n % 3 == 0) begin
                bus_write(enable_addr, $random(seed));
            end
            irq_i = (n % 5 == 4) ? '0 : irq_count'($random(seed));
            idle(2);
            claim_pulse();
            bus_read(claim_addr, rd_data);
            bus_read(pending_addr, rd_data);
            bus_read(enable_addr, rd_data);
        end

        ////////////////////////////////////////
        bus_write(32'h1000_2000, 32'hFFFF_FFFF);      // nothing is mapped in this region.
        bus_read(32'h1000_0000, rd_data);
        check_value("unmapped read", 32'h0, rd_data);
        bus_read({region_plic, 24'h003000}, rd_data);
        check_value("unknown plic offset", 32'h0, rd_data);

        ////////////////////////////////////////
        bus_read(mtime_lo_addr, first_lo);
        idle(5);
        bus_read(mtime_lo_addr, rd_data);
        check_value("mtime step", first_lo + 32'd6, rd_data);
        bus_write(cmp_hi_addr, 32'h0);
        bus_write(cmp_lo_addr, 32'h1);
        check_value("timer interrupt set", 32'h1, bus_data_t'(mti_o));
        bus_write(cmp_lo_addr, 32'hFFFF_FFFF);
        bus_write(cmp_hi_addr, 32'hFFFF_FFFF);
        check_value("timer interrupt clear", 32'h0, bus_data_t'(mti_o));
        bus_write(mtime_lo_addr, 32'hFFFF_FFF0);
        idle(20);
        bus_read(mtime_hi_addr, rd_data);
        check_value("mtime carry", 32'h1, rd_data);
        bus_read(cmp_lo_addr, rd_data);
        bus_read(cmp_hi_addr, rd_data);
        idle(4);

        if (periph_top_inst.periph_props_inst.fail_count != 0) begin
            stop_with_failure("assertion failures were counted");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- sim.f
common/periph_pkg.sv
common/irq_pkg.sv
plic/plic.sv
logic/rtc.sv
logic/periph_bus.sv
logic/periph_top.sv
testbench/periph_props.sv
testbench/periph_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module periph_tb -f sim.f -o periph_sim

# the simulation exits nonzero on failure, the log decides the result.
./obj_dir/periph_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
